// File: hw/corr_consts.svh
// Intensity correlator build configuration.
// Channel count, lag depth, counter width and sample rate.
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// Detector lines with one correlator cell each.
`define NUM_INPUTS 4

// Auto-correlation lags per channel including lag 0.
`define LAG_AUTO 4

// Counter width, also the output word width.
`define RESOLUTION 16

// intclk cycles per sample tick.
`define SAMPLE_DIV 3

// Tick divider width.
`define DIV_WIDTH ($clog2(`SAMPLE_DIV))

// Auto lags and one cross count per channel.
`define CELL_WORDS (`LAG_AUTO + 1)

// Count words in one frame, all channels.
`define COUNT_WORDS (`NUM_INPUTS * `CELL_WORDS)

// Frame word index width.
`define IDX_WIDTH ($clog2(`COUNT_WORDS))

// Header, the count words, then the tick count.
`define FRAME_WORDS (`COUNT_WORDS + 2)

`endif

// File: hw/corr_pkg.sv
// Shared types of the intensity correlator.
`include "corr_consts.svh"

package corr_pkg;

	// Saturating counter value and output word.
	typedef logic [`RESOLUTION-1:0] count_t;

	// One bit per detector line.
	typedef logic [`NUM_INPUTS-1:0] lines_t;

	// Sample history of one channel with the newest sample in bit 0.
	typedef logic [`LAG_AUTO-1:0] history_t;

	// Sampler output, shared by every cell and the packer.
	typedef struct packed {
		logic                       tick;  // One cycle per sample.
		logic                       clear; // Window start.
		history_t [`NUM_INPUTS-1:0] hist;
	} sample_frame_t;

	// Counts held by one channel cell.
	typedef struct packed {
		count_t [`LAG_AUTO-1:0] auto_cnt;
		count_t                 cross_cnt; // Lag 0 against the ring neighbor.
	} cell_counts_t;

	// Frame output sequencer.
	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		COUNTS,
		TAIL
	} packer_state_t;

endpackage

// File: hw/line_sampler.sv
// Line sampler. Divides intclk into sample ticks while integrating
// and shifts the masked detector lines into per-channel histories.
`timescale 1ns/10ps
`include "corr_consts.svh"

module line_sampler import corr_pkg::*; (
	input  logic          intclk,
	input  logic          reset,
	input  lines_t        line_in,
	input  lines_t        invert_mask,
	input  logic          integrate,
	output sample_frame_t samples
);

	logic                       integrate_d;
	logic                       rise;
	logic                       tick_now;
	logic                       tick_q;
	logic                       clear_q;
	logic [`DIV_WIDTH-1:0]      div_cnt;
	lines_t                     masked;
	history_t [`NUM_INPUTS-1:0] hist_q;

	assign rise     = integrate & ~integrate_d;
	assign masked   = line_in ^ invert_mask;
	assign tick_now = integrate & ~rise & (div_cnt == `DIV_WIDTH'(`SAMPLE_DIV - 1));

	always_ff @(posedge intclk) begin
		if (reset) begin
			integrate_d <= 1'b0;
			tick_q      <= 1'b0;
			clear_q     <= 1'b0;
			div_cnt     <= '0;
		end else begin
			integrate_d <= integrate;
			clear_q     <= rise;
			tick_q      <= tick_now;
			if (rise) begin
				div_cnt <= '0; // Divider restarts with the window.
			end else if (tick_now) begin
				div_cnt <= '0;
			end else if (integrate) begin
				div_cnt <= div_cnt + `DIV_WIDTH'(1);
			end
		end
	end

	// History shifts on the same edge that raises tick.
	always_ff @(posedge intclk) begin
		if (rise) begin
			hist_q <= '0;
		end else if (tick_now) begin
			for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
				hist_q[ch] <= {hist_q[ch][`LAG_AUTO-2:0], masked[ch]};
			end
		end
	end

	assign samples = '{tick: tick_q, clear: clear_q, hist: hist_q};

endmodule

// File: hw/correlator_cell.sv
// Correlator cell for one channel. Saturating coincidence counters
// for the auto lags and for lag 0 against the ring neighbor.
`timescale 1ns/10ps
`include "corr_consts.svh"

module correlator_cell import corr_pkg::*; (
	input  logic          intclk,
	input  logic          reset,
	input  sample_frame_t samples,
	input  history_t      own_hist,
	input  history_t      peer_hist,
	output cell_counts_t  counts
);

	logic [`LAG_AUTO-1:0] auto_hit;
	logic                 cross_hit;

	// Lag j hits when the newest sample and the lag j sample are both set.
	assign auto_hit  = own_hist & {`LAG_AUTO{own_hist[0]}};
	assign cross_hit = own_hist[0] & peer_hist[0];

	// Histories are already shifted while tick is high.
	always_ff @(posedge intclk) begin
		if (reset || samples.clear) begin
			counts <= '0;
		end else if (samples.tick) begin
			for (int j = 0; j < `LAG_AUTO; j++) begin
				if (auto_hit[j] && counts.auto_cnt[j] != '1) begin
					counts.auto_cnt[j] <= counts.auto_cnt[j] + count_t'(1);
				end
			end
			if (cross_hit && counts.cross_cnt != '1) begin
				counts.cross_cnt <= counts.cross_cnt + count_t'(1); // Holds at all ones.
			end
		end
	end

endmodule

// File: hw/frame_packer.sv
// Frame packer. Snapshots every count when the window closes and
// streams header, counts and tick total as one word per cycle.
`timescale 1ns/10ps
`include "corr_consts.svh"

module frame_packer import corr_pkg::*; (
	input  logic                           intclk,
	input  logic                           reset,
	input  logic                           integrate,
	input  sample_frame_t                  samples,
	input  cell_counts_t [`NUM_INPUTS-1:0] cell_counts,
	output count_t                         word_out,
	output logic                           word_valid,
	output logic                           busy
);

	packer_state_t         state;
	logic                  integrate_d;
	logic                  fall_q;
	logic                  start;
	logic [`IDX_WIDTH-1:0] word_idx;
	count_t                tick_cnt;
	count_t                snap_ticks;
	count_t                header;
	count_t                snap_words [`COUNT_WORDS];

	assign header = count_t'({8'(`NUM_INPUTS - 1), 8'(`LAG_AUTO - 1)});

	// A window closing during a frame is dropped.
	assign start = fall_q & ~busy;

	always_ff @(posedge intclk) begin
		if (reset || samples.clear) begin
			tick_cnt <= '0;
		end else if (samples.tick && tick_cnt != '1) begin
			tick_cnt <= tick_cnt + count_t'(1);
		end
	end

	// Fall is registered so the last tick has reached every counter.
	always_ff @(posedge intclk) begin
		if (reset) begin
			integrate_d <= 1'b0;
			fall_q      <= 1'b0;
		end else begin
			integrate_d <= integrate;
			fall_q      <= integrate_d & ~integrate;
		end
	end

	always_ff @(posedge intclk) begin
		if (start) begin
			snap_ticks <= tick_cnt;
			for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
				for (int lag = 0; lag < `LAG_AUTO; lag++) begin
					snap_words[ch * `CELL_WORDS + lag] <= cell_counts[ch].auto_cnt[lag];
				end
				snap_words[ch * `CELL_WORDS + `LAG_AUTO] <= cell_counts[ch].cross_cnt;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			state    <= IDLE;
			word_idx <= '0;
			busy     <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= HEADER;
						busy  <= 1'b1;
					end
				end
				HEADER: begin
					state    <= COUNTS;
					word_idx <= '0;
				end
				COUNTS: begin
					if (word_idx == `IDX_WIDTH'(`COUNT_WORDS - 1)) begin
						state <= TAIL;
					end else begin
						word_idx <= word_idx + `IDX_WIDTH'(1);
					end
				end
				TAIL: begin
					state <= IDLE;
					busy  <= 1'b0; // Drops after the tick word.
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_comb begin
		word_valid = (state != IDLE);
		case (state)
			HEADER:  word_out = header;
			COUNTS:  word_out = snap_words[word_idx];
			TAIL:    word_out = snap_ticks;
			default: word_out = '0;
		endcase
	end

endmodule

// File: hw/correlator_top.sv
// Intensity correlator top. Line sampler, one cell per channel
// in a ring for the cross counts, and the frame packer.
`timescale 1ns/10ps
`include "corr_consts.svh"

module correlator_top import corr_pkg::*; (
	input  logic   intclk,
	input  logic   reset,
	input  lines_t line_in,
	input  lines_t invert_mask,
	input  logic   integrate,
	output count_t word_out,
	output logic   word_valid,
	output logic   busy
);

	sample_frame_t                  samples;
	cell_counts_t [`NUM_INPUTS-1:0] cell_counts;

	line_sampler u_sampler (
		.intclk      (intclk),
		.reset       (reset),
		.line_in     (line_in),
		.invert_mask (invert_mask),
		.integrate   (integrate),
		.samples     (samples)
	);

	// Channel k pairs with channel k+1 and the last wraps to channel 0.
	for (genvar k = 0; k < `NUM_INPUTS; k++) begin : g_cell
		correlator_cell u_cell (
			.intclk    (intclk),
			.reset     (reset),
			.samples   (samples),
			.own_hist  (samples.hist[k]),
			.peer_hist (samples.hist[(k + 1) % `NUM_INPUTS]),
			.counts    (cell_counts[k])
		);
	end

	frame_packer u_packer (
		.intclk      (intclk),
		.reset       (reset),
		.integrate   (integrate),
		.samples     (samples),
		.cell_counts (cell_counts),
		.word_out    (word_out),
		.word_valid  (word_valid),
		.busy        (busy)
	);

endmodule

// File: testbench/correlator_asserts.sv
// Output protocol checks for the correlator top level.
`timescale 1ns/10ps
`include "corr_consts.svh"

module correlator_asserts (
	input logic intclk,
	input logic reset,
	input logic integrate,
	input logic word_valid,
	input logic busy
);

	int run_len;
	int fail_valid = 0;
	int fail_start = 0;
	int fail_len = 0;
	int fail_reset = 0;
	int fail_count;

	assign fail_count = fail_valid + fail_start + fail_len + fail_reset;

	// Length of the current run of valid words.
	always_ff @(posedge intclk) begin
		if (reset || !word_valid) begin
			run_len <= 0;
		end else begin
			run_len <= run_len + 1;
		end
	end

	valid_in_busy: assert property (@(posedge intclk) disable iff (reset)
		word_valid |-> busy)
		else begin
			fail_valid++;
			$error("word_valid high while busy is low");
		end

	first_word: assert property (@(posedge intclk) disable iff (reset)
		($fell(integrate) && !busy) |-> ##1 !word_valid ##1 word_valid)
		else begin
			fail_start++;
			$error("first word not 2 cycles after integrate fell");
		end

	frame_length: assert property (@(posedge intclk) disable iff (reset)
		$fell(word_valid) |-> run_len == `FRAME_WORDS)
		else begin
			fail_len++;
			$error("frame length differs from FRAME_WORDS");
		end

	reset_outputs: assert property (@(posedge intclk)
		reset |=> (!word_valid && !busy))
		else begin
			fail_reset++;
			$error("outputs not low after reset");
		end

endmodule

bind correlator_top correlator_asserts u_asserts (
	.intclk     (intclk),
	.reset      (reset),
	.integrate  (integrate),
	.word_valid (word_valid),
	.busy       (busy)
);

// File: testbench/correlator_tb.sv
// Testbench for the intensity correlator. Random and fixed windows
// checked against a model of the sampler, the cells and the frame format.
`timescale 1ns/10ps
`include "corr_consts.svh"

module correlator_tb import corr_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int TOTAL_TICKS  = 88; // All windows of the run together.
	localparam int NUM_FRAMES   = 6;
	localparam int MAX_COUNT    = (1 << `RESOLUTION) - 1;
	localparam int LIMIT_CYCLES = 2 * (TOTAL_TICKS * `SAMPLE_DIV
		+ NUM_FRAMES * (`FRAME_WORDS + 12) + 40);

	logic   intclk = 1'b0;
	logic   reset;
	lines_t line_in;
	lines_t invert_mask;
	logic   integrate;
	count_t word_out;
	logic   word_valid;
	logic   busy;

	history_t model_hist [`NUM_INPUTS];
	int       exp_auto [`NUM_INPUTS][`LAG_AUTO];
	int       exp_cross [`NUM_INPUTS];
	int       exp_ticks;
	count_t   exp_q [$];
	count_t   expected;
	int       mismatches = 0;
	int       other_errors = 0;
	int       words_seen = 0;
	int       total_errors;

	correlator_top uut (
		.intclk      (intclk),
		.reset       (reset),
		.line_in     (line_in),
		.invert_mask (invert_mask),
		.integrate   (integrate),
		.word_out    (word_out),
		.word_valid  (word_valid),
		.busy        (busy)
	);

	always #(CLK_PERIOD / 2) intclk = ~intclk;

	function automatic count_t saturate(input int value);
		return (value >= MAX_COUNT) ? '1 : count_t'(value);
	endfunction

	function automatic lines_t next_pattern(input bit all_high);
		return all_high ? '1 : lines_t'($urandom());
	endfunction

	task automatic clear_model();
		for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
			model_hist[ch] = '0;
			exp_cross[ch]  = 0;
			for (int lag = 0; lag < `LAG_AUTO; lag++) begin
				exp_auto[ch][lag] = 0;
			end
		end
		exp_ticks = 0;
	endtask

	// Every history shifts first and the counts follow.
	task automatic model_tick(input lines_t sampled);
		lines_t masked;
		masked = sampled ^ invert_mask;
		for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
			model_hist[ch] = {model_hist[ch][`LAG_AUTO-2:0], masked[ch]};
		end
		for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
			for (int lag = 0; lag < `LAG_AUTO; lag++) begin
				if (model_hist[ch][0] && model_hist[ch][lag]) begin
					exp_auto[ch][lag]++;
				end
			end
			if (model_hist[ch][0] && model_hist[(ch + 1) % `NUM_INPUTS][0]) begin
				exp_cross[ch]++;
			end
		end
		exp_ticks++;
	endtask

	task automatic push_frame();
		exp_q.push_back(count_t'(((`NUM_INPUTS - 1) << 8) | (`LAG_AUTO - 1)));
		for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
			for (int lag = 0; lag < `LAG_AUTO; lag++) begin
				exp_q.push_back(saturate(exp_auto[ch][lag]));
			end
			exp_q.push_back(saturate(exp_cross[ch]));
		end
		exp_q.push_back(saturate(exp_ticks));
	endtask

	// Each pattern is held for one tick period so the sampled value is known.
	task automatic run_window(input int ticks, input lines_t mask, input bit all_high);
		lines_t pattern;
		@(negedge intclk);
		invert_mask = mask;
		integrate   = 1'b1;
		line_in     = next_pattern(all_high);
		clear_model();
		for (int t = 0; t < ticks; t++) begin
			repeat (`SAMPLE_DIV) @(negedge intclk);
			pattern = next_pattern(all_high);
			line_in = pattern;
			model_tick(pattern);
		end
		@(negedge intclk);
		integrate = 1'b0;
		push_frame();
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0 || busy) begin
			@(negedge intclk);
		end
		@(negedge intclk);
	endtask

	// No output activity while integrate stays low.
	task automatic expect_quiet(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(negedge intclk);
			assert (!busy && !word_valid) else begin
				$display("FAIL %0t: busy or word_valid high with integrate low", $time);
				other_errors++;
			end
		end
	endtask

	// Collector samples mid-cycle.
	always @(negedge intclk) begin
		if (!reset && word_valid) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected output word %h at %0t with no frame pending", word_out, $time);
				other_errors++;
			end else begin
				expected = exp_q.pop_front();
				assert (word_out == expected) else begin
					$display("FAIL %0t: frame word %0d is %h, expected %h", $time,
						words_seen % `FRAME_WORDS, word_out, expected);
					mismatches++;
				end
			end
			words_seen++;
		end
	end

	initial begin
		void'($urandom(32'h0606_8403));
		reset       = 1'b1;
		line_in     = '0;
		invert_mask = '0;
		integrate   = 1'b0;
		repeat (5) @(negedge intclk);
		reset = 1'b0;
		expect_quiet(10);
		run_window(20, '0, 1'b0);
		wait_idle();
		run_window(20, lines_t'(32'h5), 1'b0);
		wait_idle();
		run_window(20, '0, 1'b0);
		repeat (4) @(negedge intclk);
		if (!busy) begin
			$display("Second window did not start while the first frame was streaming");
			other_errors++;
		end
		run_window(20, lines_t'(32'h3), 1'b0);
		wait_idle();
		run_window(8, '0, 1'b1);
		wait_idle();
		run_window(0, '0, 1'b0);
		wait_idle();
		repeat (5) @(negedge intclk);
		if (words_seen != NUM_FRAMES * `FRAME_WORDS) begin
			$display("Received %0d words, expected %0d", words_seen, NUM_FRAMES * `FRAME_WORDS);
			other_errors++;
		end
		total_errors = mismatches + other_errors + uut.u_asserts.fail_count;
		$display("Words %0d, mismatches %0d, other errors %0d, assertion failures %0d",
			words_seen, mismatches, other_errors, uut.u_asserts.fail_count);
		if (total_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the run did not complete", LIMIT_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+hw
hw/corr_pkg.sv
hw/line_sampler.sv
hw/correlator_cell.sv
hw/frame_packer.sv
hw/correlator_top.sv
testbench/correlator_asserts.sv
testbench/correlator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the correlator testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir --top-module correlator_tb \
	-f build.f > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vcorrelator_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0
